/* logic/rename_pkg.sv */
/* sizes, index types and the reorder buffer entry for the rename core
   imported by every rtl module and by the testbench */

package rename_pkg;

    ////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////

    localparam int arch_regs  = 8;                        // architectural registers
    localparam int rob_depth  = 8;                        // rob entries, also initial credits
    localparam int phys_regs  = arch_regs + rob_depth;    // never runs dry while credits exist
    localparam int free_depth = phys_regs - arch_regs;    // unmapped tags at reset

    ////////////////////////////////////////////////////////////
    // index types
    ////////////////////////////////////////////////////////////

    typedef logic [$clog2(arch_regs)-1:0]   arch_reg_t;   // 3 bits
    typedef logic [$clog2(phys_regs)-1:0]   phys_reg_t;   // 4 bits
    typedef logic [$clog2(rob_depth)-1:0]   rob_idx_t;    // 3 bits
    typedef logic [$clog2(rob_depth+1)-1:0] rob_count_t;  // 0 .. rob_depth
    typedef logic [$clog2(free_depth)-1:0]  free_idx_t;   // free list slot pointer

    ////////////////////////////////////////////////////////////
    // rob entry
    ////////////////////////////////////////////////////////////

    // one in-flight instruction, 11 bits
    // old_tag goes back to the free list when the entry retires
    typedef struct packed {
        arch_reg_t arch;      // destination arch register
        phys_reg_t tag;       // newly mapped tag
        phys_reg_t old_tag;   // previous mapping of arch
    } rob_entry_t;

endpackage

/* logic/free_list.sv */
/* circular list of unmapped physical register tags
   head feeds dispatch, tail takes tags freed at retirement */

`timescale 1ns/10ps

module free_list import rename_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      alloc,          // dispatch takes the head tag
    output phys_reg_t alloc_tag,      // always the head entry
    input  logic      release_valid,  // retiring entry frees a tag
    input  phys_reg_t release_tag
);

    localparam free_idx_t last_slot = free_idx_t'(free_depth - 1);

    phys_reg_t slots [free_depth];  // tag storage
    free_idx_t head;                // next tag handed out
    free_idx_t tail;                // next slot to refill

    // wrapping pointer step
    function automatic free_idx_t step(input free_idx_t ptr);
        step = (ptr == last_slot) ? '0 : ptr + 1'b1;
    endfunction

    assign alloc_tag = slots[head];  // combinational, same cycle as dispatch

    ////////////////////////////////////////////////////////////
    // pointers and storage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            head <= '0;
            tail <= '0;  // list starts full, tail sits on head
            // tags above the identity mapping, in order
            for (int i = 0; i < free_depth; i++) begin
                slots[i] <= phys_reg_t'(arch_regs + i);
            end
        end else begin
            if (alloc) begin
                head <= step(head);
            end
            // the slot at tail was consumed long ago, safe to refill
            if (release_valid) begin
                slots[tail] <= release_tag;
                tail        <= step(tail);
            end
        end
    end

endmodule

/* logic/map_table.sv */
/* architectural to physical register map
   reads both sources and the old destination tag combinationally,
   then remaps the destination at the edge on write_en */

`timescale 1ns/10ps

module map_table import rename_pkg::*; (
    input  logic      clock,
    input  logic      reset,

    // lookups
    input  arch_reg_t src1,
    input  arch_reg_t src2,
    input  arch_reg_t dest,

    // rename of dest
    input  logic      write_en,
    input  phys_reg_t new_tag,

    output phys_reg_t src1_tag,
    output phys_reg_t src2_tag,
    output phys_reg_t old_tag
);

    phys_reg_t map [arch_regs];  // current speculative mapping

    ////////////////////////////////////////////////////////////
    // lookups
    ////////////////////////////////////////////////////////////

    // all three see the table from before this cycle's write,
    // so a source equal to dest still gets the previous tag
    always_comb begin
        src1_tag = map[src1];
        src2_tag = map[src2];
        old_tag  = map[dest];  // goes into the rob, freed at retirement
    end

    ////////////////////////////////////////////////////////////
    // update
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            // identity, arch i lives in tag i
            for (int i = 0; i < arch_regs; i++) begin
                map[i] <= phys_reg_t'(i);
            end
        end else if (write_en) begin
            map[dest] <= new_tag;  // newest producer of dest
        end
    end

endmodule

/* logic/reorder_buffer.sv */
/* in-order queue of renamed instructions with a done bit per slot
   head retires once done, freeing its old tag and returning one credit
   upstream a cycle later */

`timescale 1ns/10ps

module reorder_buffer import rename_pkg::*; (
    input  logic       clock,
    input  logic       reset,

    // dispatch
    input  logic       alloc,
    input  arch_reg_t  alloc_arch,
    input  phys_reg_t  alloc_tag,
    input  phys_reg_t  alloc_old_tag,
    output rob_idx_t   alloc_idx,       // slot the dispatch lands in

    // completion
    input  logic       complete_valid,
    input  rob_idx_t   complete_idx,

    // commit
    output logic       commit_valid,
    output arch_reg_t  commit_arch,
    output phys_reg_t  commit_tag,
    output phys_reg_t  commit_old_tag,

    // to free list
    output logic       release_valid,
    output phys_reg_t  release_tag,

    output logic       credit_return    // one pulse per retired entry
);

    localparam rob_idx_t last_slot = rob_idx_t'(rob_depth - 1);

    rob_entry_t           entries [rob_depth];
    logic [rob_depth-1:0] done;        // per slot, set by completion
    rob_idx_t             head;        // oldest entry
    rob_idx_t             tail;        // next free slot
    rob_count_t           count;       // occupancy
    rob_entry_t           head_entry;
    logic                 retire;      // head leaves at this edge

    function automatic rob_idx_t step(input rob_idx_t ptr);
        step = (ptr == last_slot) ? '0 : ptr + 1'b1;
    endfunction

    ////////////////////////////////////////////////////////////
    // head and commit outputs
    ////////////////////////////////////////////////////////////

    assign head_entry = entries[head];
    assign retire     = (count != '0) && done[head];  // never stalled

    assign alloc_idx      = tail;
    assign commit_valid   = retire;
    assign commit_arch    = head_entry.arch;
    assign commit_tag     = head_entry.tag;
    assign commit_old_tag = head_entry.old_tag;
    assign release_valid  = retire;             // same cycle as commit
    assign release_tag    = head_entry.old_tag;

    ////////////////////////////////////////////////////////////
    // entry storage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (alloc) begin
            entries[tail] <= '{arch: alloc_arch, tag: alloc_tag, old_tag: alloc_old_tag};
        end
    end

    ////////////////////////////////////////////////////////////
    // pointers, done bits, occupancy
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            head          <= '0;
            tail          <= '0;
            count         <= '0;
            done          <= '0;
            credit_return <= 1'b0;
        end else begin
            if (retire) begin
                head       <= step(head);
                done[head] <= 1'b0;      // slot free again
            end
            if (alloc) begin
                tail       <= step(tail);
                done[tail] <= 1'b0;      // fresh entry, not yet executed
            end
            // completion never names the slot dispatched this cycle
            if (complete_valid) begin
                done[complete_idx] <= 1'b1;
            end

            case ({alloc, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase

            credit_return <= retire;  // registered, one cycle behind commit
        end
    end

endmodule

/* logic/rename_core.sv */
/* rename core top level
   map table and free list rename each dispatch side by side,
   the reorder buffer tracks it until in-order retirement */

`timescale 1ns/10ps

module rename_core import rename_pkg::*; (
    input  logic      clock,
    input  logic      reset,

    // dispatch, one credit per pulse
    input  logic      dispatch_valid,
    input  arch_reg_t dispatch_dest,
    input  arch_reg_t dispatch_src1,
    input  arch_reg_t dispatch_src2,
    output phys_reg_t src1_tag,
    output phys_reg_t src2_tag,
    output phys_reg_t dest_tag,
    output rob_idx_t  rob_idx,

    // completion by rob index
    input  logic      complete_valid,
    input  rob_idx_t  complete_idx,

    // commit
    output logic      commit_valid,
    output arch_reg_t commit_arch,
    output phys_reg_t commit_tag,
    output phys_reg_t commit_old_tag,
    output logic      credit_return
);

    ////////////////////////////////////////////////////////////
    // internal wires
    ////////////////////////////////////////////////////////////

    phys_reg_t old_tag;        // map table -> rob
    logic      release_valid;  // rob -> free list
    phys_reg_t release_tag;

    free_list i_free_list (
        .clock         (clock),
        .reset         (reset),
        .alloc         (dispatch_valid),
        .alloc_tag     (dest_tag),       // new tag for the dispatch
        .release_valid (release_valid),
        .release_tag   (release_tag)
    );

    map_table i_map_table (
        .clock    (clock),
        .reset    (reset),
        .src1     (dispatch_src1),
        .src2     (dispatch_src2),
        .dest     (dispatch_dest),
        .write_en (dispatch_valid),
        .new_tag  (dest_tag),
        .src1_tag (src1_tag),
        .src2_tag (src2_tag),
        .old_tag  (old_tag)
    );

    reorder_buffer i_reorder_buffer (
        .clock          (clock),
        .reset          (reset),
        .alloc          (dispatch_valid),
        .alloc_arch     (dispatch_dest),
        .alloc_tag      (dest_tag),
        .alloc_old_tag  (old_tag),
        .alloc_idx      (rob_idx),
        .complete_valid (complete_valid),
        .complete_idx   (complete_idx),
        .commit_valid   (commit_valid),
        .commit_arch    (commit_arch),
        .commit_tag     (commit_tag),
        .commit_old_tag (commit_old_tag),
        .release_valid  (release_valid),
        .release_tag    (release_tag),
        .credit_return  (credit_return)
    );

endmodule

/* testbench/rename_core_properties.sv */
/* concurrent checks bound into the reorder buffer
   cover the credit handshake, the occupancy bound and retirement order */

`timescale 1ns/10ps

module rename_core_properties import rename_pkg::*; (
    input logic                 clock,
    input logic                 reset,
    input logic                 alloc,
    input rob_idx_t             tail,
    input logic                 complete_valid,
    input rob_idx_t             complete_idx,
    input logic                 commit_valid,
    input logic                 credit_return,
    input logic [rob_depth-1:0] done,
    input rob_idx_t             head,
    input rob_count_t           count
);

    // slots that saw a completion since they were last allocated
    logic [rob_depth-1:0] completed;

    always_ff @(posedge clock) begin
        if (reset) begin
            completed <= '0;
        end else begin
            if (alloc) begin
                completed[tail] <= 1'b0;  // fresh entry
            end
            if (complete_valid) begin
                completed[complete_idx] <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // queue bounds
    ////////////////////////////////////////////////////////////

    occupancy_bound: assert property (@(posedge clock) disable iff (reset)
        count <= rob_count_t'(rob_depth))
        else $error("rob occupancy above its depth");

    // a dispatch into a full rob means upstream had no credit
    no_alloc_when_full: assert property (@(posedge clock) disable iff (reset)
        alloc |-> count != rob_count_t'(rob_depth))
        else $error("dispatch while the rob is full");

    ////////////////////////////////////////////////////////////
    // retirement
    ////////////////////////////////////////////////////////////

    credit_after_commit: assert property (@(posedge clock) disable iff (reset)
        credit_return == $past(commit_valid))
        else $error("credit_return not one cycle after commit");

    commit_only_done: assert property (@(posedge clock) disable iff (reset)
        commit_valid |-> completed[head])
        else $error("commit of an entry that is not done");

endmodule

bind reorder_buffer rename_core_properties i_rename_core_properties (.*);

/* testbench/rename_core_tb.sv */
/* testbench for the rename core
   drives a stimulus table through dispatch, completion and commit,
   checks every cycle against a model of the map, free tags and credits */

`timescale 1ns/10ps

module rename_core_tb import rename_pkg::*; ();

    localparam int half_period  = 50;     // 100 ns clock
    localparam int sample_delay = 25;     // after the falling edge drive
    localparam int credit_limit = 40;     // cycles a dispatch may wait for a credit
    localparam int drain_limit  = 80;     // cycles for the rob to empty
    localparam int rand_seed    = 31766;
    localparam int table_rows   = 16;

    typedef struct packed {
        arch_reg_t  dest;
        arch_reg_t  src1;
        arch_reg_t  src2;
        logic [3:0] delay;  // cycles to completion, 0 holds it for the shuffle
    } stim_t;

    // dest, src1, src2, delay
    stim_t stim_table [table_rows] = '{
        '{3'd3, 3'd1, 3'd2, 4'd3},
        '{3'd1, 3'd3, 3'd3, 4'd5},   // reads the fresh r3
        '{3'd2, 3'd2, 3'd1, 4'd1},   // src1 == dest, old tag
        '{3'd3, 3'd3, 3'd0, 4'd4},
        '{3'd0, 3'd1, 3'd2, 4'd2},
        '{3'd5, 3'd5, 3'd5, 4'd1},   // all three the same
        '{3'd1, 3'd0, 3'd1, 4'd6},
        '{3'd6, 3'd4, 3'd6, 4'd2},
        '{3'd4, 3'd3, 3'd4, 4'd0},   // held rows from here on
        '{3'd2, 3'd2, 3'd6, 4'd0},
        '{3'd7, 3'd0, 3'd7, 4'd0},
        '{3'd3, 3'd3, 3'd3, 4'd0},
        '{3'd0, 3'd4, 3'd2, 4'd0},
        '{3'd6, 3'd6, 3'd1, 4'd0},
        '{3'd1, 3'd7, 3'd0, 4'd0},
        '{3'd5, 3'd1, 3'd5, 4'd0}
    };

    // dut ports
    logic      clock;
    logic      reset;
    logic      dispatch_valid;
    arch_reg_t dispatch_dest;
    arch_reg_t dispatch_src1;
    arch_reg_t dispatch_src2;
    phys_reg_t src1_tag;
    phys_reg_t src2_tag;
    phys_reg_t dest_tag;
    rob_idx_t  rob_idx;
    logic      complete_valid;
    rob_idx_t  complete_idx;
    logic      commit_valid;
    arch_reg_t commit_arch;
    phys_reg_t commit_tag;
    phys_reg_t commit_old_tag;
    logic      credit_return;

    ////////////////////////////////////////////////////////////
    // reference model state
    ////////////////////////////////////////////////////////////

    phys_reg_t  model_map [arch_regs];   // arch -> tag
    logic       model_done [rob_depth];  // per rob slot
    rob_idx_t   model_tail;
    phys_reg_t  free_q [$];              // head is the next dest tag
    rob_entry_t exp_q [$];               // expected commits, dispatch order
    rob_idx_t   exp_idx_q [$];           // their rob slots
    int         credits;                 // upstream credit counter
    logic       commit_seen;             // commit in the previous cycle

    // completion scheduling
    rob_idx_t   comp_q [$];              // ready to issue, one per cycle
    rob_idx_t   wait_idx_q [$];
    int         wait_left_q [$];
    rob_idx_t   hold_q [$];              // released later in shuffled order

    phys_reg_t  freed_log [$];           // old tags in commit order
    phys_reg_t  recycled [$];
    stim_t      idle_row;
    phys_reg_t  last_src1_tag;
    phys_reg_t  last_src2_tag;
    phys_reg_t  last_dest_tag;
    rob_idx_t   last_rob_idx;
    int         last_stall;              // cycles the last dispatch waited
    int         commits;
    int         error_count;
    int         test_errors;
    int         test_number;
    int         tests_failed;
    string      test_name;

    rename_core i_rename_core (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_dest  (dispatch_dest),
        .dispatch_src1  (dispatch_src1),
        .dispatch_src2  (dispatch_src2),
        .src1_tag       (src1_tag),
        .src2_tag       (src2_tag),
        .dest_tag       (dest_tag),
        .rob_idx        (rob_idx),
        .complete_valid (complete_valid),
        .complete_idx   (complete_idx),
        .commit_valid   (commit_valid),
        .commit_arch    (commit_arch),
        .commit_tag     (commit_tag),
        .commit_old_tag (commit_old_tag),
        .credit_return  (credit_return)
    );

    initial begin
        clock = 1'b0;
        forever #half_period clock = ~clock;
    end

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_tag(input string name, input phys_reg_t actual, input phys_reg_t expected);
        if (actual !== expected) begin
            $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic check_arch(input string name, input arch_reg_t actual, input arch_reg_t expected);
        if (actual !== expected) begin
            $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic check_idx(input string name, input rob_idx_t actual, input rob_idx_t expected);
        if (actual !== expected) begin
            $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic note_timeout(input string reason);
        $display("%s at %0t", reason, $time);
        error_count++;
        test_errors++;
    endtask

    ////////////////////////////////////////////////////////////
    // one clock cycle: drive, sample, advance the model
    ////////////////////////////////////////////////////////////

    task automatic clock_cycle(input logic do_dispatch, input stim_t row);
        int         i;
        logic       do_complete;
        logic       exp_commit;
        rob_idx_t   cidx;
        rob_entry_t head;
        rob_entry_t fresh;
        @(negedge clock);
        // age the delayed completions
        i = 0;
        while (i < wait_left_q.size()) begin
            wait_left_q[i] = wait_left_q[i] - 1;
            if (wait_left_q[i] <= 0) begin
                comp_q.push_back(wait_idx_q[i]);
                wait_idx_q.delete(i);
                wait_left_q.delete(i);
            end else begin
                i++;
            end
        end
        do_complete = (comp_q.size() > 0);
        cidx        = '0;
        if (do_complete) begin
            cidx = comp_q.pop_front();
        end
        dispatch_valid = do_dispatch;
        dispatch_dest  = row.dest;
        dispatch_src1  = row.src1;
        dispatch_src2  = row.src2;
        complete_valid = do_complete;
        complete_idx   = cidx;
        #(sample_delay);

        if (do_dispatch) begin
            last_src1_tag = src1_tag;
            last_src2_tag = src2_tag;
            last_dest_tag = dest_tag;
            last_rob_idx  = rob_idx;
            check_tag("src1_tag", src1_tag, model_map[row.src1]);  // mapping before the edge
            check_tag("src2_tag", src2_tag, model_map[row.src2]);
            check_tag("dest_tag", dest_tag, free_q[0]);
            check_idx("rob_idx", rob_idx, model_tail);
        end
        exp_commit = (exp_q.size() > 0) && model_done[exp_idx_q[0]];  // head valid and done
        head       = '0;
        check_flag("commit_valid", commit_valid, exp_commit);
        if (exp_commit) begin
            head = exp_q[0];
            check_arch("commit_arch", commit_arch, head.arch);
            check_tag("commit_tag", commit_tag, head.tag);
            check_tag("commit_old_tag", commit_old_tag, head.old_tag);
        end
        check_flag("credit_return", credit_return, commit_seen);  // one cycle after commit

        // model follows the edge that ends this cycle
        if (exp_commit) begin
            model_done[exp_idx_q[0]] = 1'b0;
            free_q.push_back(head.old_tag);
            freed_log.push_back(head.old_tag);
            head = exp_q.pop_front();
            cidx = exp_idx_q.pop_front();
            commits++;
        end
        if (do_dispatch) begin
            fresh.arch    = row.dest;
            fresh.tag     = free_q.pop_front();
            fresh.old_tag = model_map[row.dest];
            exp_q.push_back(fresh);
            exp_idx_q.push_back(model_tail);
            model_map[row.dest]    = fresh.tag;
            model_done[model_tail] = 1'b0;
            if (row.delay == 4'd0) begin
                hold_q.push_back(model_tail);
            end else begin
                wait_idx_q.push_back(model_tail);
                wait_left_q.push_back(int'(row.delay));
            end
            model_tail = rob_idx_t'((int'(model_tail) + 1) % rob_depth);
            credits--;
        end
        if (do_complete) begin
            model_done[complete_idx] = 1'b1;
        end
        if (credit_return) begin
            credits++;  // upstream takes the credit back
        end
        commit_seen = exp_commit;
    endtask

    ////////////////////////////////////////////////////////////
    // sequences
    ////////////////////////////////////////////////////////////

    // no dispatch without a credit
    task automatic dispatch_row(input stim_t row);
        int waited;
        waited = 0;
        while (credits == 0 && waited < credit_limit) begin
            clock_cycle(1'b0, idle_row);
            waited++;
        end
        last_stall = waited;
        if (credits == 0) begin
            note_timeout("timed out waiting for a dispatch credit");
        end else begin
            clock_cycle(1'b1, row);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((exp_q.size() > 0 || credits != rob_depth) && waited < drain_limit) begin
            clock_cycle(1'b0, idle_row);
            waited++;
        end
        if (exp_q.size() > 0 || credits != rob_depth) begin
            note_timeout("timed out waiting for the reorder buffer to drain");
        end
    endtask

    // fisher-yates over the held slots
    task automatic release_shuffled();
        int       j;
        rob_idx_t tmp;
        for (int i = hold_q.size() - 1; i > 0; i--) begin
            j         = int'($urandom % (i + 1));
            tmp       = hold_q[i];
            hold_q[i] = hold_q[j];
            hold_q[j] = tmp;
        end
        while (hold_q.size() > 0) begin
            comp_q.push_back(hold_q.pop_front());
        end
    endtask

    task automatic begin_test(input string name);
        test_number++;
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            $display("test %0d %s: passed", test_number, test_name);
        end else begin
            $display("test %0d %s: %0d errors", test_number, test_name, test_errors);
            tests_failed++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(rand_seed));
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_dest  = '0;
        dispatch_src1  = '0;
        dispatch_src2  = '0;
        complete_valid = 1'b0;
        complete_idx   = '0;
        idle_row       = '0;
        model_tail     = '0;
        commit_seen    = 1'b0;
        credits        = rob_depth;
        commits        = 0;
        error_count    = 0;
        test_errors    = 0;
        test_number    = 0;
        tests_failed   = 0;
        last_stall     = 0;
        for (int i = 0; i < arch_regs; i++) begin
            model_map[i] = phys_reg_t'(i);  // identity
        end
        for (int i = 0; i < rob_depth; i++) begin
            model_done[i] = 1'b0;
        end
        for (int i = 0; i < free_depth; i++) begin
            free_q.push_back(phys_reg_t'(arch_regs + i));
        end
        repeat (2) @(negedge clock);
        reset = 1'b0;

        begin_test("reset state");
        clock_cycle(1'b0, idle_row);  // commit and credit quiet
        dispatch_row(stim_table[0]);
        check_tag("dest_tag", last_dest_tag, phys_reg_t'(arch_regs));
        check_idx("rob_idx", last_rob_idx, '0);
        check_tag("src1_tag", last_src1_tag, phys_reg_t'(stim_table[0].src1));
        check_tag("src2_tag", last_src2_tag, phys_reg_t'(stim_table[0].src2));
        end_test();

        begin_test("renaming");
        for (int r = 1; r < 8; r++) begin
            dispatch_row(stim_table[r]);
        end
        wait_drain();
        end_test();

        begin_test("in-order commit");
        for (int r = 8; r < table_rows; r++) begin
            dispatch_row(stim_table[r]);
        end
        repeat (3) clock_cycle(1'b0, idle_row);  // nothing done, no commit allowed
        release_shuffled();
        wait_drain();
        end_test();

        begin_test("credits");
        for (int r = 8; r < table_rows; r++) begin
            dispatch_row(stim_table[r]);
        end
        release_shuffled();
        dispatch_row(stim_table[1]);  // ninth, stalls on an empty counter
        if (last_stall == 0) begin
            $display("dispatch went ahead without waiting for a returned credit");
            error_count++;
            test_errors++;
        end
        wait_drain();
        end_test();

        begin_test("tag recycling");
        // after a drain the free list holds the last tags freed
        for (int k = freed_log.size() - free_depth; k < freed_log.size(); k++) begin
            recycled.push_back(freed_log[k]);
        end
        for (int r = 0; r < free_depth; r++) begin
            dispatch_row(stim_table[r]);
            check_tag("dest_tag", last_dest_tag, recycled[r]);
        end
        wait_drain();
        end_test();

        $display("%0d tests, %0d failed, %0d errors, %0d commits",
                 test_number, tests_failed, error_count, commits);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* rename_core.f */
logic/rename_pkg.sv
logic/free_list.sv
logic/map_table.sv
logic/reorder_buffer.sv
logic/rename_core.sv
testbench/rename_core_properties.sv
testbench/rename_core_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = rename_core_tb
FILELIST  = rename_core.f
BUILD_DIR = obj_dir
PASS_MSG  = TEST OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
